// ==== rtl/dac_pkg.sv ====
package dac_pkg;

	localparam int SAMPLE_WIDTH = 16;
	localparam int BATCH_SAMPLES = 4;
	localparam int MEM_SIZE = 7;
	localparam int WD_DATA_WIDTH = 16;

	typedef logic [SAMPLE_WIDTH-1:0] sample_t;

	// Lane 0 sits in the low bits.
	typedef logic [SAMPLE_WIDTH*BATCH_SAMPLES-1:0] batch_t;

	typedef logic [WD_DATA_WIDTH-1:0] reg_word_t;
	typedef logic [MEM_SIZE-1:0] reg_mask_t;

	// Register map layout. IDs 0 to 3 hold the lane seeds.
	localparam int SEED_BASE_ID = 0;
	localparam int SEED_VALID_ID = 4;
	localparam int TRIG_WAVE_ID = 5;
	localparam int TRI_STEP_ID = 6;

	localparam sample_t TRI_MAX = 16'h7FFF;

	typedef enum logic [1:0] {
		IDLE,
		RANDOM,
		TRIANGLE
	} dac_mode_t;

	typedef enum logic [1:0] {
		SCAN,
		WAIT_RESP,
		SETTLE
	} fetch_state_t;

endpackage

// ==== rtl/sample_src_if.sv ====
`timescale 1ns/1ps

interface sample_src_if;
	import dac_pkg::*;

	// The batch always shows the next batch to send.
	batch_t batch;
	logic active;
	logic advance;
	logic stop;

	modport producer (
		output batch,
		output active,
		input advance,
		input stop
	);

	modport consumer (
		input batch,
		input active,
		output advance,
		output stop
	);

endinterface

// ==== rtl/param_fetch.sv ====
`timescale 1ns/1ps

module param_fetch #(
	parameter int FETCH_SETTLE = 1
) (
	input logic clk,
	input logic rst,
	input dac_pkg::reg_mask_t fresh_bits,
	output dac_pkg::reg_mask_t read_reqs,
	input dac_pkg::reg_word_t [dac_pkg::MEM_SIZE-1:0] read_resps,
	output dac_pkg::sample_t [dac_pkg::BATCH_SAMPLES-1:0] seeds,
	output dac_pkg::sample_t tri_step,
	output logic rand_start,
	output logic tri_start
);
	import dac_pkg::*;

	localparam int ID_W = $clog2(MEM_SIZE);
	localparam int CNT_W = $clog2(FETCH_SETTLE + 1);

	fetch_state_t state;
	logic [ID_W-1:0] req_id;
	logic [ID_W-1:0] next_id;
	logic found;
	logic [CNT_W-1:0] settle_cnt;
	logic capture;
	reg_word_t resp;

	// Lowest fresh register wins.
	always_comb begin
		found = 1'b0;
		next_id = '0;
		for (int i = 0; i < MEM_SIZE; i++) begin
			if (fresh_bits[i] && !found) begin
				found = 1'b1;
				next_id = ID_W'(i);
			end
		end
	end

	// The map answers one cycle after the request pulse, so the response is
	// taken once read_reqs has dropped again.
	assign capture = (state == WAIT_RESP) && (read_reqs == '0);
	assign resp = read_resps[req_id];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SCAN;
			read_reqs <= '0;
			req_id <= '0;
			settle_cnt <= '0;
			rand_start <= 1'b0;
			tri_start <= 1'b0;
		end else begin
			rand_start <= capture && (int'(req_id) == SEED_VALID_ID) && (resp != '0);
			tri_start <= capture && (int'(req_id) == TRIG_WAVE_ID) && (resp != '0);
			case (state)
				SCAN: begin
					if (found) begin
						read_reqs <= reg_mask_t'(1) << next_id;
						req_id <= next_id;
						state <= WAIT_RESP;
					end
				end
				WAIT_RESP: begin
					read_reqs <= '0;
					if (capture) begin
						settle_cnt <= CNT_W'(FETCH_SETTLE - 1);
						state <= SETTLE;
					end
				end
				SETTLE: begin
					if (settle_cnt == '0) begin
						state <= SCAN;
					end else begin
						settle_cnt <= settle_cnt - 1'b1;
					end
				end
				default: state <= SCAN;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			if (int'(req_id) == TRI_STEP_ID) begin
				tri_step <= resp;
			end else if (int'(req_id) < SEED_BASE_ID + BATCH_SAMPLES) begin
				seeds[2'(int'(req_id) - SEED_BASE_ID)] <= resp;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) $onehot0(read_reqs))
		else $error("read_reqs is not one-hot: %h", read_reqs);

endmodule

// ==== rtl/rand_sample_gen.sv ====
`timescale 1ns/1ps

module rand_sample_gen (
	input logic clk,
	input logic rst,
	input dac_pkg::sample_t [dac_pkg::BATCH_SAMPLES-1:0] seeds,
	sample_src_if.producer src,
	input logic start
);
	import dac_pkg::*;

	sample_t lanes [BATCH_SAMPLES];

	function automatic sample_t xorshift16(input sample_t x);
		sample_t y;
		y = x ^ (x << 7);
		y = y ^ (y >> 9);
		y = y ^ (y << 8);
		return y;
	endfunction

	// A zero seed would lock the lane at zero forever.
	always_ff @(posedge clk) begin
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			if (start) begin
				lanes[i] <= (seeds[i] == '0) ? sample_t'(1) : seeds[i];
			end else if (src.advance && src.active) begin
				lanes[i] <= xorshift16(lanes[i]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			src.active <= 1'b0;
		end else begin
			if (start) begin
				src.active <= 1'b1;
			end
			if (src.stop) begin
				src.active <= 1'b0;
			end
		end
	end

	always_comb begin
		src.batch = '0;
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			src.batch[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lanes[i];
		end
	end

	for (genvar g = 0; g < BATCH_SAMPLES; g++) begin : g_lane_chk
		assert property (@(posedge clk) disable iff (rst) src.active |-> lanes[g] != '0)
			else $error("random lane %0d reached zero", g);
	end

endmodule

// ==== rtl/triangle_gen.sv ====
`timescale 1ns/1ps

module triangle_gen (
	input logic clk,
	input logic rst,
	input dac_pkg::sample_t tri_step,
	sample_src_if.producer src,
	input logic start
);
	import dac_pkg::*;

	typedef enum logic {
		DIR_UP,
		DIR_DOWN
	} tri_dir_t;

	sample_t value;
	tri_dir_t dir;
	sample_t eff_step;
	sample_t vals [BATCH_SAMPLES+1];
	tri_dir_t dirs [BATCH_SAMPLES+1];

	function automatic sample_t next_tri(
		input sample_t cur,
		input tri_dir_t cur_dir,
		input sample_t step,
		output tri_dir_t new_dir
	);
		logic [SAMPLE_WIDTH:0] sum;
		sample_t res;
		sum = {1'b0, cur} + {1'b0, step};
		new_dir = cur_dir;
		if (cur_dir == DIR_UP) begin
			if (sum > {1'b0, TRI_MAX}) begin
				new_dir = DIR_DOWN;
				res = cur - step;
			end else begin
				res = sum[SAMPLE_WIDTH-1:0];
			end
		end else if (cur < step) begin
			new_dir = DIR_UP;
			res = sum[SAMPLE_WIDTH-1:0];
		end else begin
			res = cur - step;
		end
		return res;
	endfunction

	assign eff_step = (tri_step == '0) ? sample_t'(1) : tri_step;

	// Unroll the wave four samples ahead; the last entry is where the next batch begins.
	always_comb begin
		vals[0] = value;
		dirs[0] = dir;
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			vals[i+1] = next_tri(vals[i], dirs[i], eff_step, dirs[i+1]);
		end
		src.batch = '0;
		for (int i = 0; i < BATCH_SAMPLES; i++) begin
			src.batch[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = vals[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= '0;
			dir <= DIR_UP;
			src.active <= 1'b0;
		end else begin
			if (start) begin
				value <= '0;
				dir <= DIR_UP;
				src.active <= 1'b1;
			end else if (src.advance && src.active) begin
				value <= vals[BATCH_SAMPLES];
				dir <= dirs[BATCH_SAMPLES];
			end
			if (src.stop) begin
				src.active <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/dac_batch_out.sv ====
`timescale 1ns/1ps

module dac_batch_out (
	input logic clk,
	input logic rst,
	input logic halt,
	input logic dac0_rdy,
	sample_src_if.consumer rand_src,
	sample_src_if.consumer tri_src,
	input logic rand_start,
	input logic tri_start,
	output dac_pkg::batch_t dac_batch,
	output logic valid_dac_batch,
	output logic [1:0] valid_dac_edge
);
	import dac_pkg::*;

	dac_mode_t mode;
	batch_t sel_batch;
	logic sel_active;
	logic send;
	logic valid_prev;

	always_comb begin
		sel_batch = '0;
		sel_active = 1'b0;
		case (mode)
			RANDOM: begin
				sel_batch = rand_src.batch;
				sel_active = rand_src.active;
			end
			TRIANGLE: begin
				sel_batch = tri_src.batch;
				sel_active = tri_src.active;
			end
			default: begin
				sel_batch = '0;
				sel_active = 1'b0;
			end
		endcase
	end

	// Without ready the generator holds its batch, so nothing is dropped.
	assign send = dac0_rdy && sel_active && !halt;

	assign rand_src.advance = send && (mode == RANDOM);
	assign tri_src.advance = send && (mode == TRIANGLE);
	assign rand_src.stop = halt || tri_start;
	assign tri_src.stop = halt || rand_start;

	always_ff @(posedge clk) begin
		if (rst) begin
			mode <= IDLE;
			dac_batch <= '0;
			valid_dac_batch <= 1'b0;
			valid_prev <= 1'b0;
		end else begin
			valid_prev <= valid_dac_batch;
			valid_dac_batch <= send;
			if (halt) begin
				mode <= IDLE;
				dac_batch <= '0;
			end else begin
				if (rand_start) begin
					mode <= RANDOM;
				end else if (tri_start) begin
					mode <= TRIANGLE;
				end
				if (send) begin
					dac_batch <= sel_batch;
				end
			end
		end
	end

	assign valid_dac_edge = {valid_prev && !valid_dac_batch, valid_dac_batch && !valid_prev};

	// After a halt the mode sits in IDLE, and while idle the output is cleared and silent.
	assert property (@(posedge clk) disable iff (rst)
		(mode == IDLE) |-> ((dac_batch == '0) && !valid_dac_batch))
		else $error("dac_batch not cleared while idle: %h", dac_batch);

endmodule

// ==== rtl/dac_interface.sv ====
`timescale 1ns/1ps

module dac_interface #(
	parameter int FETCH_SETTLE = 1
) (
	input logic clk,
	input logic rst,
	input dac_pkg::reg_mask_t fresh_bits,
	output dac_pkg::reg_mask_t read_reqs,
	input dac_pkg::reg_word_t [dac_pkg::MEM_SIZE-1:0] read_resps,
	input logic halt,
	input logic dac0_rdy,
	output dac_pkg::batch_t dac_batch,
	output logic valid_dac_batch,
	output logic [1:0] valid_dac_edge
);
	import dac_pkg::*;

	sample_t [BATCH_SAMPLES-1:0] seeds;
	sample_t tri_step;
	logic rand_start;
	logic tri_start;

	sample_src_if rand_if();
	sample_src_if tri_if();

	param_fetch #(
		.FETCH_SETTLE(FETCH_SETTLE)
	) fetch_inst (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_reqs(read_reqs),
		.read_resps(read_resps),
		.seeds(seeds),
		.tri_step(tri_step),
		.rand_start(rand_start),
		.tri_start(tri_start)
	);

	rand_sample_gen rand_inst (
		.clk(clk),
		.rst(rst),
		.seeds(seeds),
		.src(rand_if.producer),
		.start(rand_start)
	);

	triangle_gen tri_inst (
		.clk(clk),
		.rst(rst),
		.tri_step(tri_step),
		.src(tri_if.producer),
		.start(tri_start)
	);

	dac_batch_out out_inst (
		.clk(clk),
		.rst(rst),
		.halt(halt),
		.dac0_rdy(dac0_rdy),
		.rand_src(rand_if.consumer),
		.tri_src(tri_if.consumer),
		.rand_start(rand_start),
		.tri_start(tri_start),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.valid_dac_edge(valid_dac_edge)
	);

endmodule

// ==== verification/dac_interface_tb.sv ====
`timescale 1ns/1ps

module dac_interface_tb;
	import dac_pkg::*;

	localparam int WAIT_LIMIT = 300;
	localparam int RDY_OFF = 0;
	localparam int RDY_RANDOM = 1;
	localparam int RDY_HIGH = 2;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic halt = 1'b0;
	logic dac0_rdy = 1'b0;
	reg_mask_t fresh_bits = '0;
	reg_mask_t read_reqs;
	reg_word_t [MEM_SIZE-1:0] read_resps = '0;
	batch_t dac_batch;
	logic valid_dac_batch;
	logic [1:0] valid_dac_edge;

	reg_word_t regs [MEM_SIZE];
	logic wr_en = 1'b0;
	logic [2:0] wr_id = '0;
	reg_word_t wr_val = '0;
	logic [31:0] rng = 32'ha22c4ea0;
	int rdy_mode = RDY_OFF;
	logic valid_seen = 1'b0;
	logic [1:0] edge_exp;
	dac_mode_t ref_mode = IDLE;
	sample_t step_ref = 16'h0001;

	always #10 clk = ~clk;

	dac_interface #(
		.FETCH_SETTLE(1)
	) dac_interface_inst (
		.clk(clk),
		.rst(rst),
		.fresh_bits(fresh_bits),
		.read_reqs(read_reqs),
		.read_resps(read_resps),
		.halt(halt),
		.dac0_rdy(dac0_rdy),
		.dac_batch(dac_batch),
		.valid_dac_batch(valid_dac_batch),
		.valid_dac_edge(valid_dac_edge)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic sample_t lane_step(input sample_t s);
		sample_t x;
		x = s ^ (s << 7);
		x = x ^ (x >> 9);
		return x ^ (x << 8);
	endfunction

	// Returns {direction up, next sample} for one triangle step.
	function automatic logic [16:0] tri_next(input sample_t v, input logic up, input sample_t step);
		int sum;
		int diff;
		sum = int'(v) + int'(step);
		diff = int'(v) - int'(step);
		if (up) begin
			if (sum > int'(TRI_MAX)) begin
				return {1'b0, sample_t'(diff)};
			end
			return {1'b1, sample_t'(sum)};
		end
		if (diff < 0) begin
			return {1'b1, sample_t'(sum)};
		end
		return {1'b0, sample_t'(diff)};
	endfunction

	task automatic stop_on_error();
		$display("Regression failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		stop_on_error();
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s.", what);
		stop_on_error();
	endtask

	// Register map answers a request one cycle later and clears the fresh bit then.
	always @(posedge clk) begin
		if (rst) begin
			fresh_bits <= '0;
			read_resps <= '0;
			for (int i = 0; i < MEM_SIZE; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < MEM_SIZE; i++) begin
				if (read_reqs[i]) begin
					read_resps[i] <= regs[i];
					fresh_bits[i] <= 1'b0;
				end
			end
			if (wr_en) begin
				regs[wr_id] <= wr_val;
				fresh_bits[wr_id] <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		rng <= xorshift32(rng);
		case (rdy_mode)
			RDY_RANDOM: dac0_rdy <= (rng[1:0] != 2'b00);
			RDY_HIGH: dac0_rdy <= 1'b1;
			default: dac0_rdy <= 1'b0;
		endcase
	end

	// Edge flags are predicted from the valid stream seen one cycle earlier.
	// A request names one register at most, and that register must still be fresh.
	always @(negedge clk) begin
		if (!rst) begin
			edge_exp = {valid_seen && !valid_dac_batch, valid_dac_batch && !valid_seen};
			assert (valid_dac_edge == edge_exp)
				else report_value("valid_dac_edge", 64'(valid_dac_edge), 64'(edge_exp));
			assert ($onehot0(read_reqs) && ((read_reqs & ~fresh_bits) == '0)) else begin
				$display("A read request was not a single pulse to a fresh register.");
				stop_on_error();
			end
			valid_seen <= valid_dac_batch;
		end
	end

	task automatic wait_valid();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				report_timeout("valid_dac_batch");
			end
		end while (!valid_dac_batch);
	endtask

	task automatic write_reg(input int id, input reg_word_t val);
		int n;
		n = 0;
		rdy_mode = RDY_OFF;
		@(posedge clk);
		wr_en <= 1'b1;
		wr_id <= 3'(id);
		wr_val <= val;
		@(posedge clk);
		wr_en <= 1'b0;
		do begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT) begin
				report_timeout("the register read");
			end
		end while (fresh_bits[id]);
		// Capture, start pulse and generator load follow the cleared fresh bit.
		repeat (3) @(negedge clk);
		if (id == SEED_VALID_ID && val != '0) begin
			ref_mode = RANDOM;
		end else if (id == TRIG_WAVE_ID && val != '0) begin
			ref_mode = TRIANGLE;
		end else if (id == TRI_STEP_ID) begin
			step_ref = (val == '0) ? 16'h0001 : val;
		end
		rdy_mode = RDY_RANDOM;
	endtask

	task automatic check_stream(input batch_t first, input int count);
		batch_t exp;
		sample_t tv;
		sample_t cur;
		logic up;
		logic cur_up;
		exp = first;
		tv = '0;
		up = 1'b1;
		if (ref_mode == IDLE) begin
			$display("An output stream was expected while no waveform had been started.");
			stop_on_error();
		end
		for (int k = 0; k <= count; k++) begin
			wait_valid();
			assert (dac_batch == exp)
				else report_value("dac_batch", dac_batch, exp);
			if (ref_mode == RANDOM) begin
				for (int i = 0; i < BATCH_SAMPLES; i++) begin
					cur = exp[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
					exp[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = lane_step(cur);
				end
			end else begin
				for (int i = 0; i < BATCH_SAMPLES; i++) begin
					{up, tv} = tri_next(tv, up, step_ref);
				end
				cur = tv;
				cur_up = up;
				for (int i = 0; i < BATCH_SAMPLES; i++) begin
					exp[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = cur;
					{cur_up, cur} = tri_next(cur, cur_up, step_ref);
				end
			end
		end
	endtask

	task automatic quiet_check(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			assert (!valid_dac_batch)
				else report_value("valid_dac_batch", 64'(valid_dac_batch), 64'h0);
			assert (dac_batch == '0)
				else report_value("dac_batch", dac_batch, 64'h0);
			assert (read_reqs == '0)
				else report_value("read_reqs", 64'(read_reqs), 64'h0);
			@(negedge clk);
		end
	endtask

	task automatic idle_check(input int cycles);
		rdy_mode = RDY_HIGH;
		@(negedge clk);
		quiet_check(cycles);
		rdy_mode = RDY_RANDOM;
	endtask

	task automatic halt_and_check();
		rdy_mode = RDY_HIGH;
		repeat (4) @(negedge clk);
		assert (valid_dac_batch) else begin
			$display("No batch was being sent just before the halt.");
			stop_on_error();
		end
		@(posedge clk);
		halt <= 1'b1;
		@(posedge clk);
		halt <= 1'b0;
		ref_mode = IDLE;
		@(negedge clk);
		assert (valid_dac_edge == 2'b10)
			else report_value("valid_dac_edge", 64'(valid_dac_edge), 64'h2);
		quiet_check(50);
		rdy_mode = RDY_RANDOM;
	endtask

	initial begin
		int fd;
		int items;
		string line;
		logic [7:0] tag;
		logic [63:0] f1;
		logic [63:0] f2;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		fd = $fopen("verification/dac_interface_vectors.txt", "r");
		if (fd == 0) begin
			$display("The vectors file could not be opened.");
			stop_on_error();
		end
		while ($fgets(line, fd) != 0) begin
			items = $sscanf(line, "%c %h %h", tag, f1, f2);
			if (items >= 1) begin
				case (tag)
					"W": write_reg(int'(f1), reg_word_t'(f2));
					"E": check_stream(batch_t'(f1), int'(f2));
					"H": halt_and_check();
					"I": idle_check(int'(f1));
					default: ;
				endcase
			end
		end
		$fclose(fd);
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== dac_interface.f ====
rtl/dac_pkg.sv
rtl/sample_src_if.sv
rtl/param_fetch.sv
rtl/rand_sample_gen.sv
rtl/triangle_gen.sv
rtl/dac_batch_out.sv
rtl/dac_interface.sv
verification/dac_interface_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= dac_interface_tb
FILELIST ?= dac_interface.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
VECTORS := verification/dac_interface_vectors.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(VECTORS)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/dac_interface_vectors.txt ====
# Columns: tag, then up to two hex fields.
# W <reg id> <value> writes a register, E <first batch> <batches after it>, H halts, I <cycles> idles.
I 28
W 0 BEEF
W 1 BEF0
W 2 BEF1
W 3 BEF2
W 4 0001
E BEF2BEF1BEF0BEEF 30
W 6 1000
W 5 0001
E 3000200010000000 20
H
W 0 0000
W 4 0001
E BEF2BEF1BEF00001 30
W 5 0001
E 3000200010000000 12
H
I 14
